// File: Makefile
# Verilator simulation of the audio playback controller

VERILATOR ?= verilator
TOP ?= tb_audio_controller
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_TEXT ?= TEST PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: audio_channel.sv
// --------------------------------------------------
// One playback channel. Fetches stereo words over
// the shared DMA port into a small buffer and plays
// one word per sample strobe. An append descriptor
// waits until the current block is fetched.
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "audio_settings.svh"

module audio_channel (
	input wire i_clock,
	input wire i_rst,

	input wire audio_pkg::dma_setup_t i_setup,

	output audio_pkg::dma_req_t o_dma,
	input wire i_grant_ready,
	input wire [`AUDIO_DATA_WIDTH-1:0] i_dma_rdata,

	input wire i_sample_strobe,
	output audio_pkg::stereo_sample_t o_sample,
	output logic o_busy
);

	localparam int PTR_BITS = $clog2(`AUDIO_BUFFER_DEPTH);
	localparam int FILL_BITS = $clog2(`AUDIO_BUFFER_DEPTH + 1);
	localparam logic [FILL_BITS-1:0] FILL_FULL = FILL_BITS'(`AUDIO_BUFFER_DEPTH);

	logic [`AUDIO_ADDR_WIDTH-1:0] cur_address;
	logic [`AUDIO_COUNT_WIDTH-1:0] cur_count;
	logic [`AUDIO_ADDR_WIDTH-1:0] next_address;
	logic [`AUDIO_COUNT_WIDTH-1:0] next_count;

	logic pend_valid;
	logic [`AUDIO_ADDR_WIDTH-1:0] pend_address;
	logic [`AUDIO_COUNT_WIDTH-1:0] pend_count;

	audio_pkg::stereo_sample_t buffer [`AUDIO_BUFFER_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [FILL_BITS-1:0] fill;

	logic setup_replace;
	logic setup_append;
	logic fetch;
	logic pop;

	always_comb begin
		setup_replace = i_setup.valid && (i_setup.mode == audio_pkg::SETUP_REPLACE);
		setup_append = i_setup.valid && (i_setup.mode == audio_pkg::SETUP_APPEND);
		// A word landing during a replace belongs to the old block
		fetch = i_grant_ready && !setup_replace;
		pop = i_sample_strobe && (fill != '0);
		next_address = fetch ? cur_address + `AUDIO_ADDR_WIDTH'(`AUDIO_WORD_BYTES) : cur_address;
		next_count = fetch ? cur_count - 1'b1 : cur_count;
	end

	assign o_dma.request = (fill < FILL_FULL) && (cur_count != '0);
	assign o_dma.address = cur_address;
	assign o_busy = (cur_count != '0) || pend_valid || (fill != '0);

	// Descriptor and pending append
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			cur_count <= '0;
			pend_valid <= 1'b0;
		end else if (setup_replace) begin
			cur_address <= i_setup.address;
			cur_count <= i_setup.count;
			pend_valid <= 1'b0;
		end else begin
			if (next_count == '0 && pend_valid) begin
				cur_address <= pend_address;
				cur_count <= pend_count;
				pend_valid <= 1'b0;
			end else begin
				cur_address <= next_address;
				cur_count <= next_count;
			end

			if (setup_append) begin
				if (next_count == '0 && !pend_valid) begin
					cur_address <= i_setup.address;
					cur_count <= i_setup.count;
				end else begin
					pend_address <= i_setup.address;
					pend_count <= i_setup.count;
					pend_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (fetch) begin
			buffer[wr_ptr] <= audio_pkg::stereo_sample_t'(i_dma_rdata);
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst || setup_replace) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (fetch) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({fetch, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// Underrun plays silence
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_sample <= '0;
		end else if (i_sample_strobe) begin
			o_sample <= (fill != '0) ? buffer[rd_ptr] : '0;
		end
	end

endmodule

`default_nettype wire

// File: audio_controller.sv
// --------------------------------------------------
// Top level of the DMA audio playback controller.
// CPU port programs the channels, the channels share
// one DMA master port and the mixer drives the
// stereo output. Sample strobe is a one-cycle pulse.
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "audio_settings.svh"

module audio_controller (
	input wire i_clock,
	input wire i_rst,

	input wire i_request,
	input wire i_rw,
	input wire [`AUDIO_REG_ADDR_WIDTH-1:0] i_address,
	input wire [`AUDIO_DATA_WIDTH-1:0] i_wdata,
	output logic [`AUDIO_DATA_WIDTH-1:0] o_rdata,
	output logic o_ready,

	output logic o_dma_request,
	output logic [`AUDIO_ADDR_WIDTH-1:0] o_dma_address,
	input wire i_dma_ready,
	input wire [`AUDIO_DATA_WIDTH-1:0] i_dma_rdata,

	input wire i_output_sample_strobe,
	output logic [`AUDIO_DATA_WIDTH-1:0] o_output_sample_rate,
	output logic [`AUDIO_SAMPLE_WIDTH-1:0] o_output_sample_left,
	output logic [`AUDIO_SAMPLE_WIDTH-1:0] o_output_sample_right
);

	logic [`AUDIO_NUM_CHANNELS-1:0] busy;
	logic [`AUDIO_NUM_CHANNELS-1:0] grant_ready;
	audio_pkg::dma_setup_t [`AUDIO_NUM_CHANNELS-1:0] setup;
	audio_pkg::dma_req_t [`AUDIO_NUM_CHANNELS-1:0] dma_req;
	audio_pkg::stereo_sample_t [`AUDIO_NUM_CHANNELS-1:0] samples;

	audio_regs u_regs (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.i_busy(busy),
		.o_setup(setup),
		.o_sample_rate(o_output_sample_rate)
	);

	for (genvar ch = 0; ch < `AUDIO_NUM_CHANNELS; ch++) begin : g_channel
		audio_channel u_channel (
			.i_clock(i_clock),
			.i_rst(i_rst),
			.i_setup(setup[ch]),
			.o_dma(dma_req[ch]),
			.i_grant_ready(grant_ready[ch]),
			.i_dma_rdata(i_dma_rdata),
			.i_sample_strobe(i_output_sample_strobe),
			.o_sample(samples[ch]),
			.o_busy(busy[ch])
		);
	end

	audio_dma_scheduler u_scheduler (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_req(dma_req),
		.o_grant_ready(grant_ready),
		.o_dma_request(o_dma_request),
		.o_dma_address(o_dma_address),
		.i_dma_ready(i_dma_ready)
	);

	audio_mixer u_mixer (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_samples(samples),
		.o_left(o_output_sample_left),
		.o_right(o_output_sample_right)
	);

endmodule

`default_nettype wire

// File: audio_dma_scheduler.sv
// --------------------------------------------------
// Round-robin arbiter for the shared DMA master port.
// Serves one channel request at a time, holds the
// request until the slave answers with ready and
// routes that ready back to the served channel.
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "audio_settings.svh"

module audio_dma_scheduler (
	input wire i_clock,
	input wire i_rst,

	input wire audio_pkg::dma_req_t [`AUDIO_NUM_CHANNELS-1:0] i_req,
	output logic [`AUDIO_NUM_CHANNELS-1:0] o_grant_ready,

	output logic o_dma_request,
	output logic [`AUDIO_ADDR_WIDTH-1:0] o_dma_address,
	input wire i_dma_ready
);

	localparam logic [`AUDIO_CHANNEL_BITS-1:0] PTR_LAST =
		`AUDIO_CHANNEL_BITS'(`AUDIO_NUM_CHANNELS - 1);

	audio_pkg::sched_state_e state;
	logic [`AUDIO_CHANNEL_BITS-1:0] ptr;
	logic [`AUDIO_CHANNEL_BITS-1:0] ptr_next;

	always_comb begin
		ptr_next = (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
	end

	assign o_dma_request = (state == audio_pkg::SCHED_WAIT);

	always_comb begin
		o_grant_ready = '0;
		if (state == audio_pkg::SCHED_WAIT) begin
			o_grant_ready[ptr] = i_dma_ready;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= audio_pkg::SCHED_SCAN;
			ptr <= '0;
		end else begin
			case (state)
				audio_pkg::SCHED_SCAN: begin
					if (i_req[ptr].request) begin
						o_dma_address <= i_req[ptr].address;
						state <= audio_pkg::SCHED_WAIT;
					end else begin
						ptr <= ptr_next;
					end
				end
				audio_pkg::SCHED_WAIT: begin
					// Request and address hold while the slave stalls
					if (i_dma_ready) begin
						ptr <= ptr_next;
						state <= audio_pkg::SCHED_SCAN;
					end
				end
				default: state <= audio_pkg::SCHED_SCAN;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: audio_mixer.sv
// --------------------------------------------------
// Sums the samples of all channels per side.
// Signed, wraps on overflow, one cycle of latency.
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "audio_settings.svh"

module audio_mixer (
	input wire i_clock,
	input wire i_rst,
	input wire audio_pkg::stereo_sample_t [`AUDIO_NUM_CHANNELS-1:0] i_samples,
	output logic signed [`AUDIO_SAMPLE_WIDTH-1:0] o_left,
	output logic signed [`AUDIO_SAMPLE_WIDTH-1:0] o_right
);

	logic signed [`AUDIO_SAMPLE_WIDTH-1:0] sum_left;
	logic signed [`AUDIO_SAMPLE_WIDTH-1:0] sum_right;

	always_comb begin
		sum_left = '0;
		sum_right = '0;
		for (int ch = 0; ch < `AUDIO_NUM_CHANNELS; ch++) begin
			sum_left = sum_left + i_samples[ch].left;
			sum_right = sum_right + i_samples[ch].right;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_left <= '0;
			o_right <= '0;
		end else begin
			o_left <= sum_left;
			o_right <= sum_right;
		end
	end

endmodule

`default_nettype wire

// File: audio_pkg.sv
// --------------------------------------------------
// Shared types of the audio playback controller.
// Referenced by scoped names from the RTL modules.
// --------------------------------------------------
`default_nettype none

`include "audio_settings.svh"

package audio_pkg;

	typedef enum logic [0:0] {
		SETUP_REPLACE = 1'b0,
		SETUP_APPEND = 1'b1
	} setup_mode_e;

	// Channel c sits at REG_CH_ADDRESS + 2c and REG_CH_COUNT + 2c
	typedef enum logic [`AUDIO_REG_ADDR_WIDTH-1:0] {
		REG_RATE = 4'd0,
		REG_BUSY = 4'd1,
		REG_CH_ADDRESS = 4'd2,
		REG_CH_COUNT = 4'd3
	} reg_addr_e;

	typedef enum logic [0:0] {
		SCHED_SCAN = 1'b0,
		SCHED_WAIT = 1'b1
	} sched_state_e;

	typedef struct packed {
		logic valid;
		setup_mode_e mode;
		logic [`AUDIO_COUNT_WIDTH-1:0] count;
		logic [`AUDIO_ADDR_WIDTH-1:0] address;
	} dma_setup_t;

	typedef struct packed {
		logic request;
		logic [`AUDIO_ADDR_WIDTH-1:0] address;
	} dma_req_t;

	// Left in the low half as in a fetched word
	typedef struct packed {
		logic signed [`AUDIO_SAMPLE_WIDTH-1:0] right;
		logic signed [`AUDIO_SAMPLE_WIDTH-1:0] left;
	} stereo_sample_t;

endpackage

`default_nettype wire

// File: audio_regs.sv
// --------------------------------------------------
// CPU register block of the audio controller.
// Holds the rate divider, returns the busy mask and
// stages per-channel addresses. A count write sends
// a one-cycle setup strobe to its channel.
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "audio_settings.svh"

module audio_regs (
	input wire i_clock,
	input wire i_rst,

	input wire i_request,
	input wire i_rw,
	input wire [`AUDIO_REG_ADDR_WIDTH-1:0] i_address,
	input wire [`AUDIO_DATA_WIDTH-1:0] i_wdata,
	output logic [`AUDIO_DATA_WIDTH-1:0] o_rdata,
	output logic o_ready,

	input wire [`AUDIO_NUM_CHANNELS-1:0] i_busy,
	output audio_pkg::dma_setup_t [`AUDIO_NUM_CHANNELS-1:0] o_setup,
	output logic [`AUDIO_DATA_WIDTH-1:0] o_sample_rate
);

	localparam logic [`AUDIO_REG_ADDR_WIDTH-1:0] CH_REG_SPAN =
		`AUDIO_REG_ADDR_WIDTH'(2 * `AUDIO_NUM_CHANNELS);
	localparam logic [`AUDIO_REG_ADDR_WIDTH-1:0] COUNT_ADDR = audio_pkg::REG_CH_COUNT;

	logic [`AUDIO_ADDR_WIDTH-1:0] staged_address [`AUDIO_NUM_CHANNELS];

	logic [`AUDIO_REG_ADDR_WIDTH-1:0] ch_offset;
	logic [`AUDIO_CHANNEL_BITS-1:0] ch_index;
	logic ch_hit;
	logic ch_is_count;

	// Channel register decode
	always_comb begin
		ch_offset = i_address - audio_pkg::REG_CH_ADDRESS;
		ch_hit = (i_address >= audio_pkg::REG_CH_ADDRESS) && (ch_offset < CH_REG_SPAN);
		ch_index = ch_offset[`AUDIO_CHANNEL_BITS:1];
		ch_is_count = (i_address[0] == COUNT_ADDR[0]);
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
			o_sample_rate <= `AUDIO_DATA_WIDTH'(`AUDIO_RATE_RESET);
			for (int ch = 0; ch < `AUDIO_NUM_CHANNELS; ch++) begin
				o_setup[ch].valid <= 1'b0;
			end
		end else begin
			for (int ch = 0; ch < `AUDIO_NUM_CHANNELS; ch++) begin
				o_setup[ch].valid <= 1'b0;
			end

			if (i_request && !o_ready) begin
				o_ready <= 1'b1;
				o_rdata <= '0;
				if (i_rw) begin
					if (i_address == audio_pkg::REG_RATE) begin
						o_sample_rate <= i_wdata;
					end else if (ch_hit && !ch_is_count) begin
						staged_address[ch_index] <= i_wdata;
					end else if (ch_hit) begin
						o_setup[ch_index] <= '{
							valid: 1'b1,
							mode: audio_pkg::setup_mode_e'(i_wdata[`AUDIO_APPEND_BIT]),
							count: i_wdata[`AUDIO_COUNT_WIDTH-1:0],
							address: staged_address[ch_index]
						};
					end
				end else begin
					case (i_address)
						audio_pkg::REG_RATE: o_rdata <= o_sample_rate;
						audio_pkg::REG_BUSY:
							o_rdata <= {{(`AUDIO_DATA_WIDTH - `AUDIO_NUM_CHANNELS){1'b0}}, i_busy};
						default: o_rdata <= '0;
					endcase
				end
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: audio_settings.svh
// --------------------------------------------------
// Build-time sizes of the audio playback controller.
// Included by the package and by every RTL file
// that needs a width or a count.
// --------------------------------------------------
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

`define AUDIO_NUM_CHANNELS 4
`define AUDIO_CHANNEL_BITS 2

`define AUDIO_ADDR_WIDTH 32
`define AUDIO_DATA_WIDTH 32
`define AUDIO_COUNT_WIDTH 24
`define AUDIO_SAMPLE_WIDTH 16
`define AUDIO_REG_ADDR_WIDTH 4

// Bit 31 of a count write selects append
`define AUDIO_APPEND_BIT 31
`define AUDIO_WORD_BYTES 4
`define AUDIO_BUFFER_DEPTH 2
`define AUDIO_RATE_RESET 17

`endif

// File: compile.f
+incdir+.
audio_pkg.sv
audio_regs.sv
audio_channel.sv
audio_dma_scheduler.sv
audio_mixer.sv
audio_controller.sv
tb_audio_controller.sv

// File: tb_audio_controller.sv
// --------------------------------------------------
// Testbench for the DMA audio playback controller.
// Drives the CPU port, models a DMA memory with a
// random ready delay and checks the mixed output
// against words derived from the fetch addresses.
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "audio_settings.svh"

module tb_audio_controller;

	localparam int NCH = `AUDIO_NUM_CHANNELS;
	localparam int LOG_SIZE = 64;

	logic i_clock = 1'b0;
	logic i_rst;
	logic i_request;
	logic i_rw;
	logic [`AUDIO_REG_ADDR_WIDTH-1:0] i_address;
	logic [`AUDIO_DATA_WIDTH-1:0] i_wdata;
	logic [`AUDIO_DATA_WIDTH-1:0] o_rdata;
	logic o_ready;
	logic o_dma_request;
	logic [`AUDIO_ADDR_WIDTH-1:0] o_dma_address;
	logic i_dma_ready = 1'b0;
	logic [`AUDIO_DATA_WIDTH-1:0] i_dma_rdata = '0;
	logic i_output_sample_strobe;
	logic [`AUDIO_DATA_WIDTH-1:0] o_output_sample_rate;
	logic [`AUDIO_SAMPLE_WIDTH-1:0] o_output_sample_left;
	logic [`AUDIO_SAMPLE_WIDTH-1:0] o_output_sample_right;

	// DMA memory model and its fetch log
	logic [31:0] lcg_state = 32'h9a7fb76e;
	bit dma_stall = 1'b0;
	int delay_left = -1;
	logic [31:0] served_addr;
	int served_ch;
	logic [31:0] ch_log [NCH][LOG_SIZE];
	int fetch_cnt [NCH];
	int grant_log [LOG_SIZE*NCH];
	int log_len = 0;

	// Expected playback per channel
	logic [31:0] exp_addr [NCH][LOG_SIZE];
	int exp_len [NCH];
	int played [NCH];
	int mark [NCH];

	string test_name;
	int errors = 0;
	int test_errors;
	int tests_run = 0;
	int tests_failed = 0;

	audio_controller DUT (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_dma_request(o_dma_request),
		.o_dma_address(o_dma_address),
		.i_dma_ready(i_dma_ready),
		.i_dma_rdata(i_dma_rdata),
		.i_output_sample_strobe(i_output_sample_strobe),
		.o_output_sample_rate(o_output_sample_rate),
		.o_output_sample_left(o_output_sample_left),
		.o_output_sample_right(o_output_sample_right)
	);

	always #2 i_clock = ~i_clock;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Low address bits on the left and their inverse on the right
	function automatic logic [31:0] model_word(input logic [31:0] addr);
		return {~addr[15:0], addr[15:0]};
	endfunction

	// Channel c buffers live at (c + 1) << 16
	function automatic logic [1:0] addr_channel(input logic [31:0] addr);
		return addr[17:16] - 2'd1;
	endfunction

	// Ready after 0 to 3 cycles and a log entry once the word is written
	always @(negedge i_clock) begin
		if (i_dma_ready) begin
			i_dma_ready <= 1'b0;
			ch_log[served_ch][fetch_cnt[served_ch]] <= served_addr;
			fetch_cnt[served_ch] <= fetch_cnt[served_ch] + 1;
			grant_log[log_len] <= served_ch;
			log_len <= log_len + 1;
		end else if (o_dma_request && !dma_stall) begin
			if (delay_left < 0) begin
				delay_left = int'(lcg_next() >> 16) % 4;
			end
			if (delay_left == 0) begin
				served_addr = o_dma_address;
				served_ch = int'(addr_channel(o_dma_address));
				i_dma_rdata <= model_word(o_dma_address);
				i_dma_ready <= 1'b1;
				delay_left = -1;
			end else begin
				delay_left--;
			end
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == test_errors) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed", test_name);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout in test %s: %s", test_name, what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("test %s: %s", test_name, what);
			errors++;
		end
	endtask

	task automatic cpu_access(input logic rw, input logic [`AUDIO_REG_ADDR_WIDTH-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		i_request = 1'b1;
		i_rw = rw;
		i_address = addr;
		i_wdata = wdata;
		@(negedge i_clock);
		while (!o_ready) begin
			waited++;
			if (waited > 16) begin
				abort_on_timeout("CPU ready never rose");
			end
			@(negedge i_clock);
		end
		rdata = o_rdata;
		i_request = 1'b0;
		waited = 0;
		@(negedge i_clock);
		while (o_ready) begin
			waited++;
			if (waited > 16) begin
				abort_on_timeout("CPU ready never fell");
			end
			@(negedge i_clock);
		end
	endtask

	task automatic cpu_write(input logic [`AUDIO_REG_ADDR_WIDTH-1:0] addr,
			input logic [31:0] data);
		logic [31:0] unused;
		cpu_access(1'b1, addr, data, unused);
	endtask

	task automatic cpu_read(input logic [`AUDIO_REG_ADDR_WIDTH-1:0] addr,
			output logic [31:0] data);
		cpu_access(1'b0, addr, 32'h0, data);
	endtask

	// A replace drops whatever the channel still held
	task automatic program_channel(input int ch, input logic [31:0] base, input int count,
			input bit append);
		cpu_write(4'(audio_pkg::REG_CH_ADDRESS + 2 * ch), base);
		if (!append) begin
			exp_len[ch] = 0;
			played[ch] = 0;
			mark[ch] = fetch_cnt[ch];
		end
		cpu_write(4'(audio_pkg::REG_CH_COUNT + 2 * ch), {append, 7'd0, 24'(count)});
		for (int k = 0; k < count; k++) begin
			exp_addr[ch][exp_len[ch]] = base + 32'(4 * k);
			exp_len[ch]++;
		end
	endtask

	task automatic wait_buffered(input int ch, input int words);
		int waited;
		waited = 0;
		while (fetch_cnt[ch] - mark[ch] < words) begin
			waited++;
			if (waited > 100) begin
				abort_on_timeout("channel buffer did not fill");
			end
			@(negedge i_clock);
		end
	endtask

	task automatic wait_dma_request();
		int waited;
		waited = 0;
		while (!o_dma_request) begin
			waited++;
			if (waited > 20) begin
				abort_on_timeout("DMA request never rose");
			end
			@(negedge i_clock);
		end
	endtask

	task automatic play_strobe(input bit wait_data);
		logic [15:0] exp_left;
		logic [15:0] exp_right;
		logic [31:0] word;
		int waited;
		bit missing;
		waited = 0;
		missing = wait_data;
		while (missing) begin
			missing = 1'b0;
			for (int ch = 0; ch < NCH; ch++) begin
				if (played[ch] < exp_len[ch] && fetch_cnt[ch] <= mark[ch]) begin
					missing = 1'b1;
				end
			end
			if (missing) begin
				waited++;
				if (waited > 100) begin
					abort_on_timeout("no buffered data for a strobe");
				end
				@(negedge i_clock);
			end
		end
		exp_left = '0;
		exp_right = '0;
		for (int ch = 0; ch < NCH; ch++) begin
			if (fetch_cnt[ch] > mark[ch]) begin
				check_true(played[ch] < exp_len[ch], "channel fetched more words than programmed");
				word = model_word(exp_addr[ch][played[ch]]);
				exp_left = exp_left + word[15:0];
				exp_right = exp_right + word[31:16];
				played[ch]++;
				mark[ch]++;
			end
		end
		i_output_sample_strobe = 1'b1;
		@(negedge i_clock);
		i_output_sample_strobe = 1'b0;
		@(negedge i_clock);
		check_value("left sample", 32'(exp_left), 32'(o_output_sample_left));
		check_value("right sample", 32'(exp_right), 32'(o_output_sample_right));
	endtask

	// All channels request throughout, so between two grants to one
	// channel each other channel is served exactly once
	function automatic bit round_robin_ok(input int first, input int last);
		bit [NCH-1:0] seen;
		bit dup;
		int j;
		for (int i = first; i < last; i++) begin
			seen = '0;
			dup = 1'b0;
			j = i + 1;
			while (j < last && grant_log[j] != grant_log[i]) begin
				if (seen[grant_log[j]]) begin
					dup = 1'b1;
				end
				seen[grant_log[j]] = 1'b1;
				j++;
			end
			if (j < last && (dup || (j - i) != NCH)) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	initial begin
		logic [31:0] rdata;
		logic [31:0] bases [NCH];
		int first;
		int first_log;
		bases = '{32'h0001_7ff0, 32'h0002_6000, 32'h0003_9000, 32'h0004_c000};
		i_rst = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_output_sample_strobe = 1'b0;
		repeat (2) @(negedge i_clock);
		i_rst = 1'b0;
		@(negedge i_clock);

		start_test("reset values");
		check_value("cpu ready", 32'h0, 32'(o_ready));
		check_value("dma request", 32'h0, 32'(o_dma_request));
		check_value("left output", 32'h0, 32'(o_output_sample_left));
		check_value("right output", 32'h0, 32'(o_output_sample_right));
		check_value("rate output", 32'd17, o_output_sample_rate);
		cpu_read(audio_pkg::REG_RATE, rdata);
		check_value("rate read", 32'd17, rdata);
		cpu_read(audio_pkg::REG_BUSY, rdata);
		check_value("busy read", 32'h0, rdata);
		finish_test();

		start_test("register access");
		cpu_write(audio_pkg::REG_RATE, 32'h0000_0240);
		check_value("rate output", 32'h0000_0240, o_output_sample_rate);
		cpu_read(audio_pkg::REG_RATE, rdata);
		check_value("rate read", 32'h0000_0240, rdata);
		cpu_read(4'hd, rdata);
		check_value("unmapped read", 32'h0, rdata);
		finish_test();

		start_test("single channel replace");
		first = fetch_cnt[1];
		first_log = log_len;
		program_channel(1, 32'h0002_1000, 5, 1'b0);
		wait_buffered(1, 2);
		cpu_read(audio_pkg::REG_BUSY, rdata);
		check_value("busy during playback", 32'h2, rdata);
		repeat (5) play_strobe(1'b1);
		cpu_read(audio_pkg::REG_BUSY, rdata);
		check_value("busy after playback", 32'h0, rdata);
		check_value("channel fetches", 32'd5, 32'(fetch_cnt[1] - first));
		check_value("total fetches", 32'd5, 32'(log_len - first_log));
		for (int k = 0; k < 5; k++) begin
			check_value("dma address", 32'h0002_1000 + 32'(4 * k), ch_log[1][first + k]);
		end
		finish_test();

		start_test("round robin mixing");
		// Slave held off so that all four channels request together
		@(posedge i_clock);
		dma_stall = 1'b1;
		@(negedge i_clock);
		first_log = log_len;
		for (int ch = 0; ch < NCH; ch++) begin
			program_channel(ch, bases[ch], 4, 1'b0);
		end
		@(posedge i_clock);
		dma_stall = 1'b0;
		@(negedge i_clock);
		for (int ch = 0; ch < NCH; ch++) begin
			wait_buffered(ch, 2);
		end
		check_value("grant count", 32'(2 * NCH), 32'(log_len - first_log));
		check_true(round_robin_ok(first_log, log_len),
			"a requesting channel was skipped between two grants to another channel");
		repeat (4) play_strobe(1'b1);
		finish_test();

		start_test("append and replace");
		first = fetch_cnt[2];
		program_channel(2, 32'h0003_0000, 3, 1'b0);
		wait_buffered(2, 2);
		program_channel(2, 32'h0003_8000, 2, 1'b1);
		repeat (5) play_strobe(1'b1);
		for (int k = 0; k < 5; k++) begin
			check_value("append address", exp_addr[2][k], ch_log[2][first + k]);
		end
		program_channel(3, 32'h0004_0000, 6, 1'b0);
		wait_buffered(3, 2);
		first = fetch_cnt[3];
		program_channel(3, 32'h0004_9000, 2, 1'b0);
		repeat (2) play_strobe(1'b1);
		check_value("address after replace", 32'h0004_9000, ch_log[3][first]);
		check_value("second address after replace", 32'h0004_9004, ch_log[3][first + 1]);
		finish_test();

		start_test("underrun");
		program_channel(0, 32'h0001_2000, 3, 1'b0);
		wait_buffered(0, 2);
		@(posedge i_clock);
		dma_stall = 1'b1;
		@(negedge i_clock);
		repeat (2) play_strobe(1'b1);
		wait_dma_request();
		repeat (3) @(negedge i_clock);
		check_true(o_dma_request, "DMA request dropped while the slave stalled");
		check_value("stalled address", 32'h0001_2008, o_dma_address);
		check_true(fetch_cnt[0] == mark[0], "channel 0 still held data at the underrun strobe");
		play_strobe(1'b0);
		@(posedge i_clock);
		dma_stall = 1'b0;
		@(negedge i_clock);
		play_strobe(1'b1);
		finish_test();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
